/* include/dma_defines.svh */
// DMA target constants: flit field positions, type codes and size limits
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Widths
`define DMA_FLIT_W       34
`define DMA_DATA_W       32
`define DMA_TILE_W       5
`define DMA_ID_W         4
`define DMA_SIZE_W       12

// Packet length limits, in flits and words
`define DMA_PKT_FLITS    16
`define DMA_MAX_PAYLOAD  14

// Flit field positions
`define DMA_TYPE_MSB     33
`define DMA_TYPE_LSB     32
`define DMA_DEST_MSB     31
`define DMA_DEST_LSB     27
`define DMA_CLASS_MSB    26
`define DMA_CLASS_LSB    24
`define DMA_ID_MSB       23
`define DMA_ID_LSB       20
`define DMA_SRC_MSB      19
`define DMA_SRC_LSB      15
`define DMA_PTYPE_MSB    14
`define DMA_PTYPE_LSB    13
`define DMA_LAST_BIT     12
`define DMA_SIZE_MSB     11
`define DMA_SIZE_LSB     0
`define DMA_CONTENT_MSB  31
`define DMA_CONTENT_LSB  0

// Flit type codes
`define DMA_FLIT_PAYLOAD 2'd0
`define DMA_FLIT_HEADER  2'd1
`define DMA_FLIT_LAST    2'd2
`define DMA_FLIT_SINGLE  2'd3

// Packet class and packet type codes
`define DMA_CLASS_DMA    3'd6
`define DMA_PT_L2R_REQ   2'd0
`define DMA_PT_L2R_RESP  2'd1
`define DMA_PT_R2L_REQ   2'd2
`define DMA_PT_R2L_RESP  2'd3

`endif

/* src/dma_pkg.sv */
// DMA target package: shared vector types and the controller state encoding
`include "dma_defines.svh"

package dma_pkg;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  // One NoC flit, flit type in the two top bits
  typedef logic [`DMA_FLIT_W-1:0] flit_t;

  // Local and remote byte addresses
  typedef logic [`DMA_DATA_W-1:0] addr_t;

  // One memory word
  typedef logic [`DMA_DATA_W-1:0] data_t;

  // Tile number on the NoC
  typedef logic [`DMA_TILE_W-1:0] tile_t;

  // Request id, echoed in every response
  typedef logic [`DMA_ID_W-1:0] pkt_id_t;

  // Word count, same width as the size field
  typedef logic [`DMA_SIZE_W-1:0] wsize_t;

  //////////////////////////////////////////////////
  // Controller FSM
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    st_idle,      // waiting for a request header
    st_l2r_addr,  // local address flit of a write request
    st_l2r_data,  // payload words onto the bus
    st_l2r_resp,  // single-flit acknowledgement
    st_r2l_laddr, // local address flit of a read request
    st_r2l_raddr, // remote address flit of a read request
    st_r2l_hdr,   // response header out
    st_r2l_addr,  // response address out
    st_r2l_data   // response payload out
  } ctrl_state_t;

endpackage

/* src/dma_bus_if.sv */
// Local memory bus bundle: single-phase AHB-Lite style select, address and data
`timescale 1ns/1ps

interface dma_bus_if;
  import dma_pkg::*;

  // Request side, driven by the DMA controller
  logic  hsel;
  logic  hwrite;
  addr_t haddr;
  data_t hwdata;

  // Response side, driven by the memory
  data_t hrdata;
  logic  hready;

  // Controller view
  modport master (
    output hsel, hwrite, haddr, hwdata,
    input  hrdata, hready
  );

  // Memory view, as seen from the top level pins
  modport port (
    input  hsel, hwrite, haddr, hwdata,
    output hrdata, hready
  );

endinterface

/* src/dma_packet_buffer.sv */
// Packet buffer: flit FIFO that only presents flits once a whole packet is held
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_packet_buffer (
  input  logic           clk,
  input  logic           rst,
  input  dma_pkg::flit_t in_flit,
  input  logic           in_valid,
  output logic           in_ready,
  output dma_pkg::flit_t out_flit,
  output logic           out_valid,
  input  logic           out_ready
);
  import dma_pkg::*;

  localparam int DEPTH = `DMA_PKT_FLITS;
  localparam int AW    = $clog2(DEPTH);

  flit_t        mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;     // flits stored
  logic [AW:0]   pkt_count; // complete packets stored
  logic          push;
  logic          pop;

  // True for the flit that closes a packet
  function automatic logic closes_pkt(flit_t f);
    logic [1:0] ftype;
    ftype = f[`DMA_TYPE_MSB:`DMA_TYPE_LSB];
    return (ftype == `DMA_FLIT_LAST) || (ftype == `DMA_FLIT_SINGLE);
  endfunction

  assign in_ready  = (count != (AW + 1)'(DEPTH));
  assign push      = in_valid & in_ready;
  // Nothing leaves before its packet is complete
  assign out_valid = (pkt_count != '0);
  assign pop       = out_valid & out_ready;
  assign out_flit  = mem[rd_ptr];

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      pkt_count <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + (AW + 1)'(push) - (AW + 1)'(pop);
      // Packet count, in on a stored end flit, out on a released one
      pkt_count <= pkt_count + (AW + 1)'(push && closes_pkt(in_flit))
                             - (AW + 1)'(pop && closes_pkt(out_flit));
    end
  end

  // Flit storage
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= in_flit;
  end

endmodule

/* src/dma_read_fifo.sv */
// Read data FIFO: three-entry shift FIFO between bus read data and the NoC output
`timescale 1ns/1ps

module dma_read_fifo (
  input  logic           clk,
  input  logic           rst,
  input  logic           push,
  input  dma_pkg::data_t din,
  input  logic           pop,
  output dma_pkg::data_t dout,
  output logic           empty,
  output logic           full
);
  import dma_pkg::*;

  data_t      mem [3];
  // One-hot write position, bit 3 marks all three entries in use
  logic [3:0] pos;

  assign empty = pos[0];
  assign full  = pos[3];
  assign dout  = mem[0]; // head of queue

  // Position moves only when occupancy changes
  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= 4'b0001;
    end else if (push && !pop) begin
      pos <= pos << 1;
    end else if (pop && !push) begin
      pos <= pos >> 1;
    end
  end

  //////////////////////////////////////////////////
  // Entry shifting
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (pop) begin
      // Shift toward the head, the new word lands one slot below its pointer
      mem[0] <= (push && pos[1]) ? din : mem[1];
      mem[1] <= (push && pos[2]) ? din : mem[2];
      if (push && pos[3])
        mem[2] <= din;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (push && pos[i])
          mem[i] <= din;
      end
    end
  end

endmodule

/* src/dma_target_ctrl.sv */
// DMA target controller: decodes requests, sequences the memory bus, builds responses
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_target_ctrl #(
  parameter dma_pkg::tile_t TILE_ID = '0
) (
  input  logic           clk,
  input  logic           rst,
  input  dma_pkg::flit_t buf_flit,
  input  logic           buf_valid,
  output logic           buf_ready,
  dma_bus_if.master      bus,
  output logic           fifo_push,
  output logic           fifo_pop,
  input  dma_pkg::data_t fifo_dout,
  input  logic           fifo_empty,
  input  logic           fifo_full,
  output dma_pkg::flit_t noc_out_flit,
  output logic           noc_out_valid,
  input  logic           noc_out_ready
);
  import dma_pkg::*;

  ctrl_state_t state;
  ctrl_state_t nxt_state;

  // Request fields, taken from the header flit
  tile_t   src_tile;
  pkt_id_t pkt_id;
  logic    last_req;
  wsize_t  wsize;

  // Addresses
  addr_t   laddr; // local, steps by one word per bus transfer
  addr_t   raddr; // remote base for the response address flits

  // Response bookkeeping
  wsize_t  sent;       // words in chunks already finished
  wsize_t  chunk;      // words in the current chunk
  wsize_t  chunk_cnt;  // words of the current chunk on the NoC
  wsize_t  fetch_left; // words of the current chunk still to read

  logic [1:0] buf_ftype;
  logic [1:0] buf_ptype;
  logic       buf_hdr;
  logic       buf_closes;
  wsize_t     remain;
  wsize_t     chunk_size;
  logic       final_chunk;
  logic       chunk_end;
  logic       rd_en;
  logic       wr_en;
  logic       xfer;
  logic       out_fire;

  //////////////////////////////////////////////////
  // Decode and datapath helpers
  //////////////////////////////////////////////////

  assign buf_ftype  = buf_flit[`DMA_TYPE_MSB:`DMA_TYPE_LSB];
  assign buf_ptype  = buf_flit[`DMA_PTYPE_MSB:`DMA_PTYPE_LSB];
  assign buf_hdr    = (buf_ftype == `DMA_FLIT_HEADER);
  assign buf_closes = (buf_ftype == `DMA_FLIT_LAST) || (buf_ftype == `DMA_FLIT_SINGLE);

  // Size of the next response chunk
  assign remain      = wsize - sent;
  assign final_chunk = (remain <= wsize_t'(`DMA_MAX_PAYLOAD));
  assign chunk_size  = final_chunk ? remain : wsize_t'(`DMA_MAX_PAYLOAD);
  assign chunk_end   = (chunk_cnt == chunk - wsize_t'(1));

  // Reads run ahead of the NoC as long as the FIFO has room
  assign rd_en = ((state == st_r2l_addr) || (state == st_r2l_data)) &&
                 (fetch_left != '0) && !fifo_full;
  // Whole packet is buffered, so valid stays high through the payload
  assign wr_en = (state == st_l2r_data) && buf_valid;

  assign bus.hsel   = rd_en | wr_en;
  assign bus.hwrite = wr_en;
  assign bus.haddr  = laddr;
  assign bus.hwdata = buf_flit[`DMA_CONTENT_MSB:`DMA_CONTENT_LSB];

  assign xfer      = bus.hsel & bus.hready;
  assign fifo_push = rd_en & bus.hready;
  assign out_fire  = noc_out_valid & noc_out_ready;
  assign fifo_pop  = (state == st_r2l_data) && out_fire;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    nxt_state     = state;
    buf_ready     = 1'b0;
    noc_out_valid = 1'b0;
    noc_out_flit  = '0;
    case (state)
      st_idle: begin
        // Flits that are not a known request header are dropped here
        buf_ready = 1'b1;
        if (buf_valid && buf_hdr) begin
          case (buf_ptype)
            `DMA_PT_L2R_REQ: nxt_state = st_l2r_addr;
            `DMA_PT_R2L_REQ: nxt_state = st_r2l_laddr;
            default:         nxt_state = st_idle;
          endcase
        end
      end
      st_l2r_addr: begin
        buf_ready = 1'b1;
        if (buf_valid)
          nxt_state = st_l2r_data;
      end
      st_l2r_data: begin
        // Flit consumed in the cycle its word is written
        buf_ready = bus.hready;
        if (xfer && buf_closes)
          nxt_state = last_req ? st_l2r_resp : st_idle;
      end
      st_l2r_resp: begin
        noc_out_valid = 1'b1;
        noc_out_flit[`DMA_TYPE_MSB:`DMA_TYPE_LSB]   = `DMA_FLIT_SINGLE;
        noc_out_flit[`DMA_DEST_MSB:`DMA_DEST_LSB]   = src_tile;
        noc_out_flit[`DMA_CLASS_MSB:`DMA_CLASS_LSB] = `DMA_CLASS_DMA;
        noc_out_flit[`DMA_ID_MSB:`DMA_ID_LSB]       = pkt_id;
        noc_out_flit[`DMA_SRC_MSB:`DMA_SRC_LSB]     = TILE_ID;
        noc_out_flit[`DMA_PTYPE_MSB:`DMA_PTYPE_LSB] = `DMA_PT_L2R_RESP;
        if (noc_out_ready)
          nxt_state = st_idle;
      end
      st_r2l_laddr: begin
        buf_ready = 1'b1;
        if (buf_valid)
          nxt_state = st_r2l_raddr;
      end
      st_r2l_raddr: begin
        buf_ready = 1'b1;
        // A zero-length read has nothing to return
        if (buf_valid)
          nxt_state = (wsize == '0) ? st_idle : st_r2l_hdr;
      end
      st_r2l_hdr: begin
        noc_out_valid = 1'b1;
        noc_out_flit[`DMA_TYPE_MSB:`DMA_TYPE_LSB]   = `DMA_FLIT_HEADER;
        noc_out_flit[`DMA_DEST_MSB:`DMA_DEST_LSB]   = src_tile;
        noc_out_flit[`DMA_CLASS_MSB:`DMA_CLASS_LSB] = `DMA_CLASS_DMA;
        noc_out_flit[`DMA_ID_MSB:`DMA_ID_LSB]       = pkt_id;
        noc_out_flit[`DMA_SRC_MSB:`DMA_SRC_LSB]     = TILE_ID;
        noc_out_flit[`DMA_PTYPE_MSB:`DMA_PTYPE_LSB] = `DMA_PT_R2L_RESP;
        noc_out_flit[`DMA_LAST_BIT]                 = final_chunk;
        noc_out_flit[`DMA_SIZE_MSB:`DMA_SIZE_LSB]   = chunk_size;
        if (noc_out_ready)
          nxt_state = st_r2l_addr;
      end
      st_r2l_addr: begin
        noc_out_valid = 1'b1;
        noc_out_flit[`DMA_TYPE_MSB:`DMA_TYPE_LSB] = `DMA_FLIT_PAYLOAD;
        // Remote base plus the bytes already returned
        noc_out_flit[`DMA_CONTENT_MSB:`DMA_CONTENT_LSB] = raddr + (addr_t'(sent) << 2);
        if (noc_out_ready)
          nxt_state = st_r2l_data;
      end
      st_r2l_data: begin
        noc_out_valid = !fifo_empty;
        noc_out_flit[`DMA_TYPE_MSB:`DMA_TYPE_LSB] =
          chunk_end ? `DMA_FLIT_LAST : `DMA_FLIT_PAYLOAD;
        noc_out_flit[`DMA_CONTENT_MSB:`DMA_CONTENT_LSB] = fifo_dout;
        if (!fifo_empty && noc_out_ready && chunk_end)
          nxt_state = final_chunk ? st_idle : st_r2l_hdr;
      end
      default: nxt_state = st_idle;
    endcase
  end

  // State and counters
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      sent       <= '0;
      chunk_cnt  <= '0;
      fetch_left <= '0;
    end else begin
      state <= nxt_state;
      if (state == st_r2l_raddr && buf_valid)
        sent <= '0;
      else if (fifo_pop && chunk_end)
        sent <= sent + chunk;
      // New chunk starts when its header is taken
      if (state == st_r2l_hdr && out_fire) begin
        fetch_left <= chunk_size;
        chunk_cnt  <= '0;
      end else begin
        if (fifo_push)
          fetch_left <= fetch_left - wsize_t'(1);
        if (fifo_pop)
          chunk_cnt <= chunk_cnt + wsize_t'(1);
      end
    end
  end

  // Request fields and addresses
  always_ff @(posedge clk) begin
    if (state == st_idle && buf_valid && buf_hdr) begin
      src_tile <= buf_flit[`DMA_SRC_MSB:`DMA_SRC_LSB];
      pkt_id   <= buf_flit[`DMA_ID_MSB:`DMA_ID_LSB];
      last_req <= buf_flit[`DMA_LAST_BIT];
      wsize    <= buf_flit[`DMA_SIZE_MSB:`DMA_SIZE_LSB];
    end
    if ((state == st_l2r_addr || state == st_r2l_laddr) && buf_valid)
      laddr <= buf_flit[`DMA_CONTENT_MSB:`DMA_CONTENT_LSB];
    else if (xfer)
      laddr <= laddr + addr_t'(4);
    if (state == st_r2l_raddr && buf_valid)
      raddr <= buf_flit[`DMA_CONTENT_MSB:`DMA_CONTENT_LSB];
    if (state == st_r2l_hdr && out_fire)
      chunk <= chunk_size;
  end

endmodule

/* src/dma_target.sv */
// DMA target top: NoC request buffer, read FIFO and controller on a local memory bus
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_target #(
  parameter logic [`DMA_TILE_W-1:0] TILE_ID = '0
) (
  input  logic                   clk,
  input  logic                   rst,
  // NoC request input
  input  logic [`DMA_FLIT_W-1:0] noc_in_flit,
  input  logic                   noc_in_valid,
  output logic                   noc_in_ready,
  // NoC response output
  output logic [`DMA_FLIT_W-1:0] noc_out_flit,
  output logic                   noc_out_valid,
  input  logic                   noc_out_ready,
  // Local memory bus
  output logic                   hsel,
  output logic                   hwrite,
  output logic [`DMA_DATA_W-1:0] haddr,
  output logic [`DMA_DATA_W-1:0] hwdata,
  input  logic [`DMA_DATA_W-1:0] hrdata,
  input  logic                   hready
);
  import dma_pkg::*;

  flit_t buf_flit;
  logic  buf_valid;
  logic  buf_ready;
  logic  fifo_push;
  logic  fifo_pop;
  data_t fifo_dout;
  logic  fifo_empty;
  logic  fifo_full;

  dma_bus_if bus ();

  // Memory bus pins
  assign hsel       = bus.hsel;
  assign hwrite     = bus.hwrite;
  assign haddr      = bus.haddr;
  assign hwdata     = bus.hwdata;
  assign bus.hrdata = hrdata;
  assign bus.hready = hready;

  // Holds request flits until their packet is complete
  dma_packet_buffer packet_buffer_inst (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (noc_in_flit),
    .in_valid  (noc_in_valid),
    .in_ready  (noc_in_ready),
    .out_flit  (buf_flit),
    .out_valid (buf_valid),
    .out_ready (buf_ready)
  );

  // Read words waiting for the NoC
  dma_read_fifo read_fifo_inst (
    .clk   (clk),
    .rst   (rst),
    .push  (fifo_push),
    .din   (bus.hrdata),
    .pop   (fifo_pop),
    .dout  (fifo_dout),
    .empty (fifo_empty),
    .full  (fifo_full)
  );

  dma_target_ctrl #(
    .TILE_ID (TILE_ID)
  ) ctrl_inst (
    .clk           (clk),
    .rst           (rst),
    .buf_flit      (buf_flit),
    .buf_valid     (buf_valid),
    .buf_ready     (buf_ready),
    .bus           (bus),
    .fifo_push     (fifo_push),
    .fifo_pop      (fifo_pop),
    .fifo_dout     (fifo_dout),
    .fifo_empty    (fifo_empty),
    .fifo_full     (fifo_full),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready)
  );

endmodule

/* sim/tb_dma_target.sv */
// DMA target testbench with memory model, NoC driver and monitor, and directed request tests
`timescale 1ns/1ps
`include "dma_defines.svh"

module tb_dma_target;
  import dma_pkg::*;

  // Room for all five tests, including the random stalls of test 5
  localparam int TIMEOUT_CYCLES = 20000;
  localparam tile_t TB_TILE = 5'd9;

  logic  clk = 1'b0;
  logic  rst;
  flit_t noc_in_flit;
  logic  noc_in_valid;
  logic  noc_in_ready;
  flit_t noc_out_flit;
  logic  noc_out_valid;
  logic  noc_out_ready = 1'b1;
  logic  hsel;
  logic  hwrite;
  data_t haddr;
  data_t hwdata;
  data_t hrdata;
  logic  hready = 1'b1;

  data_t mem [1024];
  flit_t tx_q [$];     // request flits to send
  flit_t rx_q [$];     // response flits collected
  data_t wr_words [$]; // payload of the last write request
  logic  rand_mode = 1'b0;
  int    errors = 0;
  int    checks = 0;
  int    cycles = 0;

  dma_target #(
    .TILE_ID (TB_TILE)
  ) dma_target_inst (
    .clk           (clk),
    .rst           (rst),
    .noc_in_flit   (noc_in_flit),
    .noc_in_valid  (noc_in_valid),
    .noc_in_ready  (noc_in_ready),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready),
    .hsel          (hsel),
    .hwrite        (hwrite),
    .haddr         (haddr),
    .hwdata        (hwdata),
    .hrdata        (hrdata),
    .hready        (hready)
  );

  always #2 clk = ~clk;

  // Initial memory contents depend on the whole word index
  function automatic data_t fill_word(input int idx);
    return (32'(idx) * 32'h9e3779b1) ^ 32'h5a00_0000 ^ 32'(idx);
  endfunction

  //////////////////////////////////////////////////
  // Memory model, back-pressure, monitor, timeout
  //////////////////////////////////////////////////

  // Read data answers in the same cycle
  assign hrdata = mem[haddr[11:2]];

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 1024; i++)
        mem[i] <= fill_word(i);
    end else if (hsel && hready && hwrite) begin
      mem[haddr[11:2]] <= hwdata;
    end
    noc_out_ready <= rand_mode ? 1'($urandom % 2) : 1'b1;
    hready        <= rand_mode ? (($urandom % 4) != 0) : 1'b1;
  end

  // Collect every accepted response flit
  always @(posedge clk) begin
    if (!rst && noc_out_valid && noc_out_ready)
      rx_q.push_back(noc_out_flit);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic flit_t make_hdr(input logic [1:0] ptype, input logic last,
                                     input wsize_t size, input pkt_id_t id, input tile_t src);
    flit_t f;
    f = '0;
    f[`DMA_TYPE_MSB:`DMA_TYPE_LSB]   = `DMA_FLIT_HEADER;
    f[`DMA_DEST_MSB:`DMA_DEST_LSB]   = TB_TILE;
    f[`DMA_CLASS_MSB:`DMA_CLASS_LSB] = `DMA_CLASS_DMA;
    f[`DMA_ID_MSB:`DMA_ID_LSB]       = id;
    f[`DMA_SRC_MSB:`DMA_SRC_LSB]     = src;
    f[`DMA_PTYPE_MSB:`DMA_PTYPE_LSB] = ptype;
    f[`DMA_LAST_BIT]                 = last;
    f[`DMA_SIZE_MSB:`DMA_SIZE_LSB]   = size;
    return f;
  endfunction

  // Sends tx_q as one packet and holds each flit until it is accepted
  task automatic send_packet();
    foreach (tx_q[i]) begin
      noc_in_flit  <= tx_q[i];
      noc_in_valid <= 1'b1;
      @(posedge clk);
      while (!noc_in_ready)
        @(posedge clk);
    end
    noc_in_valid <= 1'b0;
    tx_q.delete();
  endtask

  task automatic send_l2r(input pkt_id_t id, input tile_t src, input logic last,
                          input addr_t laddr, input int n);
    data_t w;
    wr_words.delete();
    tx_q.push_back(make_hdr(`DMA_PT_L2R_REQ, last, wsize_t'(n), id, src));
    tx_q.push_back({`DMA_FLIT_PAYLOAD, laddr});
    for (int i = 0; i < n; i++) begin
      w = $urandom;
      wr_words.push_back(w);
      tx_q.push_back({(i == n - 1) ? `DMA_FLIT_LAST : `DMA_FLIT_PAYLOAD, w});
    end
    send_packet();
  endtask

  task automatic wait_rx(input int n, input int limit);
    int waited;
    waited = 0;
    while (rx_q.size() < n && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    if (rx_q.size() < n) begin
      errors++;
      $display("Only %0d of %0d response flits arrived in %0d cycles", rx_q.size(), n, limit);
    end
    // Time for any extra flit to show up
    repeat (20) @(posedge clk);
  endtask

  task automatic check_mem(input addr_t laddr);
    foreach (wr_words[i])
      check("mem", 64'(mem[laddr[11:2] + 10'(i)]), 64'(wr_words[i]));
  endtask

  task automatic check_ack(input pkt_id_t id, input tile_t src);
    check("ack_count", 64'(rx_q.size()), 64'(1));
    if (rx_q.size() > 0) begin
      check("ack_type", 64'(rx_q[0][`DMA_TYPE_MSB:`DMA_TYPE_LSB]), 64'(`DMA_FLIT_SINGLE));
      check("ack_ptype", 64'(rx_q[0][`DMA_PTYPE_MSB:`DMA_PTYPE_LSB]), 64'(`DMA_PT_L2R_RESP));
      check("ack_dest", 64'(rx_q[0][`DMA_DEST_MSB:`DMA_DEST_LSB]), 64'(src));
      check("ack_id", 64'(rx_q[0][`DMA_ID_MSB:`DMA_ID_LSB]), 64'(id));
    end
    rx_q.delete();
  endtask

  // Read request plus a check of every packet it returns
  task automatic run_r2l(input int n, input addr_t laddr, input addr_t raddr,
                         input pkt_id_t id, input tile_t src);
    int total;
    int sent;
    int len;
    int k;
    flit_t f;
    total = n + 2 * ((n + `DMA_MAX_PAYLOAD - 1) / `DMA_MAX_PAYLOAD);
    tx_q.push_back(make_hdr(`DMA_PT_R2L_REQ, 1'b0, wsize_t'(n), id, src));
    tx_q.push_back({`DMA_FLIT_PAYLOAD, laddr});
    tx_q.push_back({`DMA_FLIT_LAST, raddr});
    send_packet();
    wait_rx(total, 60 * total + 200);
    check("rx_count", 64'(rx_q.size()), 64'(total));
    sent = 0;
    k = 0;
    while (sent < n && k + 1 < rx_q.size()) begin
      len = (n - sent > `DMA_MAX_PAYLOAD) ? `DMA_MAX_PAYLOAD : n - sent;
      f = rx_q[k];
      check("hdr_type", 64'(f[`DMA_TYPE_MSB:`DMA_TYPE_LSB]), 64'(`DMA_FLIT_HEADER));
      check("hdr_ptype", 64'(f[`DMA_PTYPE_MSB:`DMA_PTYPE_LSB]), 64'(`DMA_PT_R2L_RESP));
      check("hdr_dest", 64'(f[`DMA_DEST_MSB:`DMA_DEST_LSB]), 64'(src));
      check("hdr_src", 64'(f[`DMA_SRC_MSB:`DMA_SRC_LSB]), 64'(TB_TILE));
      check("hdr_id", 64'(f[`DMA_ID_MSB:`DMA_ID_LSB]), 64'(id));
      check("hdr_size", 64'(f[`DMA_SIZE_MSB:`DMA_SIZE_LSB]), 64'(len));
      check("hdr_last", 64'(f[`DMA_LAST_BIT]), 64'(sent + len == n));
      check("raddr", 64'(rx_q[k + 1]), 64'({`DMA_FLIT_PAYLOAD, raddr + 32'(4 * sent)}));
      k += 2;
      for (int i = 0; i < len && k < rx_q.size(); i++) begin
        check("data", 64'(rx_q[k]), 64'({(i == len - 1) ? `DMA_FLIT_LAST : `DMA_FLIT_PAYLOAD,
                                        fill_word(int'(laddr[11:2]) + sent + i)}));
        k++;
      end
      sent += len;
    end
    rx_q.delete();
  endtask

  task automatic report(input string name, input int err0);
    $display("%s: %s", name, (errors == err0) ? "ok" : "failed");
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  initial begin
    int err0;
    void'($urandom(18769));
    rst <= 1'b1;
    noc_in_flit  <= '0;
    noc_in_valid <= 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    // Test 1 checks the idle outputs after reset and a write with acknowledgement
    err0 = errors;
    check("noc_out_valid", 64'(noc_out_valid), 64'(0));
    check("hsel", 64'(hsel), 64'(0));
    check("noc_in_ready", 64'(noc_in_ready), 64'(1));
    send_l2r(4'd3, 5'd4, 1'b1, 32'h100, 4);
    wait_rx(1, 200);
    check_mem(32'h100);
    check_ack(4'd3, 5'd4);
    report("test 1 l2r with ack", err0);

    // Test 2 sends a silent write and then a write with the last flag
    err0 = errors;
    send_l2r(4'd5, 5'd6, 1'b0, 32'h200, 3);
    repeat (200) @(posedge clk);
    check("silent_count", 64'(rx_q.size()), 64'(0));
    check_mem(32'h200);
    rx_q.delete();
    send_l2r(4'd6, 5'd6, 1'b1, 32'h300, 2);
    wait_rx(1, 200);
    check_mem(32'h300);
    check_ack(4'd6, 5'd6);
    report("test 2 l2r without ack", err0);

    // Test 3 reads five words in one packet
    err0 = errors;
    run_r2l(5, 32'h400, 32'h8000_0000, 4'd7, 5'd2);
    report("test 3 r2l 5 words", err0);

    // Test 4 reads 30 words split over three packets
    err0 = errors;
    run_r2l(30, 32'h600, 32'h4000_1000, 4'd8, 5'd3);
    report("test 4 r2l 30 words", err0);

    // Test 5 reads under random bus and NoC stalls
    err0 = errors;
    rand_mode <= 1'b1;
    run_r2l(20, 32'h800, 32'h2000_0040, 4'd9, 5'd5);
    rand_mode <= 1'b0;
    report("test 5 r2l random stalls", err0);

    $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
src/dma_pkg.sv
src/dma_bus_if.sv
src/dma_packet_buffer.sv
src/dma_read_fifo.sv
src/dma_target_ctrl.sv
src/dma_target.sv
sim/tb_dma_target.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the DMA target testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_dma_target \
  -f vlog.f --Mdir obj_dir -o tb_dma_target

./obj_dir/tb_dma_target > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  exit 1
fi
grep -q "PASS: all tests" sim.log
